// File: tb.f
+incdir+dv
verilog/cpc_pkg.sv
verilog/ext_page_decode.sv
verilog/rom_loader.sv
verilog/mf2_store_map.sv
verilog/mf2_control.sv
verilog/mf2_ram.sv
verilog/cpc_expansion_top.sv
dv/tb_cpc_expansion.sv

// File: dv/tb_cpc_vectors.svh
/*
 * CPC expansion test vectors
 * One row per operation on the loader or CPU side, with its expected result
 */
`ifndef TB_CPC_VECTORS_SVH
`define TB_CPC_VECTORS_SVH

typedef enum logic [3:0] {
	OP_LD_START, OP_LD_WR, OP_IO_WR, OP_KEY, OP_M1, OP_ADDR, OP_RD, OP_MODE, OP_DONE
} op_e;

// Columns are kind, address, data, random data bits, expected, readback source
typedef struct packed {
	op_e         kind;
	logic [24:0] addr;	// Loader address, or {model, extension} on a download start
	logic [7:0]  data;	// Loader index, mode or test number for the control rows
	logic [7:0]  rmask;	// Random loader rows also get a random offset
	logic [11:0] exp;	// {wr, bank, page} for loader writes, byte or flag otherwise
	int          src;	// Row whose drawn byte is read back, -1 for exp
} vec_t;

vec_t vecs [50] = '{
	////////////////////////////////////////
	// ROM slots
	'{OP_LD_START, 25'h0000000, 8'h00, 8'h00, 12'h000, -1},
	'{OP_LD_WR,    25'h0000000, 8'h00, 8'hFF, {1'b1, 2'd0, 9'h000}, -1},	// OS
	'{OP_LD_WR,    25'h0004000, 8'h00, 8'hFF, {1'b1, 2'd0, 9'h100}, -1},	// BASIC
	'{OP_LD_WR,    25'h0008000, 8'h00, 8'hFF, {1'b1, 2'd0, 9'h107}, -1},	// AMSDOS
	'{OP_LD_WR,    25'h000C000, 8'h00, 8'hFF, {1'b1, 2'd0, 9'h0FF}, -1},	// MF2
	'{OP_LD_WR,    25'h0010000, 8'h00, 8'hFF, {1'b1, 2'd1, 9'h000}, -1},	// 664 set
	'{OP_LD_WR,    25'h0014000, 8'h00, 8'hFF, {1'b1, 2'd1, 9'h100}, -1},
	'{OP_LD_WR,    25'h0018000, 8'h00, 8'hFF, {1'b1, 2'd1, 9'h107}, -1},
	'{OP_LD_WR,    25'h001C000, 8'h00, 8'hFF, {1'b1, 2'd1, 9'h0FF}, -1},
	'{OP_LD_WR,    25'h0024000, 8'h00, 8'hFF, {1'b0, 2'd0, 9'h000}, -1},	// Slot 9 dropped
	'{OP_DONE,     25'h0000000, 8'd1,  8'h00, 12'h000, -1},
	////////////////////////////////////////
	// Expansion pages
	'{OP_LD_START, 25'h0003141, 8'h03, 8'h00, 12'h000, -1},	// "1A", model 0
	'{OP_LD_WR,    25'h0008000, 8'h00, 8'hFF, {1'b1, 2'd0, 9'h11C}, -1},
	'{OP_LD_START, 25'h0014733, 8'h03, 8'h00, 12'h000, -1},	// "G3", model 1
	'{OP_LD_WR,    25'h0004000, 8'h00, 8'hFF, {1'b1, 2'd1, 9'h1E4}, -1},
	'{OP_LD_START, 25'h0015A5A, 8'h03, 8'h00, 12'h000, -1},	// "ZZ", model 1
	'{OP_LD_WR,    25'h0000000, 8'h00, 8'hFF, {1'b1, 2'd1, 9'h000}, -1},
	'{OP_LD_START, 25'h0005A30, 8'h03, 8'h00, 12'h000, -1},	// "Z0" combo
	'{OP_LD_WR,    25'h0003FFF, 8'hC3, 8'h00, {1'b1, 2'd0, 9'h000}, -1},	// Last combo byte
	'{OP_LD_WR,    25'h0000000, 8'h00, 8'hFF, {1'b1, 2'd0, 9'h1FF}, -1},
	'{OP_DONE,     25'h0000000, 8'd2,  8'h00, 12'h000, -1},
	////////////////////////////////////////
	// Shadow stores and readback
	'{OP_IO_WR,    25'h0007F00, 8'h05, 8'h00, 12'h000, -1},	// Pen 5
	'{OP_IO_WR,    25'h0007F00, 8'h40, 8'h1F, 12'h000, -1},	// Colour
	'{OP_IO_WR,    25'h000BC00, 8'h02, 8'h00, 12'h000, -1},	// CRTC R2
	'{OP_IO_WR,    25'h000BD00, 8'h00, 8'hFF, 12'h000, -1},
	'{OP_KEY,      25'h0000000, 8'h00, 8'h00, 12'd1, -1},
	'{OP_M1,       25'h0000066, 8'h00, 8'h00, 12'd0, -1},
	'{OP_RD,       25'h0003F95, 8'h00, 8'h00, 12'h000, 22},
	'{OP_RD,       25'h0003DB2, 8'h00, 8'h00, 12'h000, 24},
	'{OP_DONE,     25'h0000000, 8'd3,  8'h00, 12'h000, -1},
	////////////////////////////////////////
	// Paging control
	'{OP_ADDR,     25'h0001234, 8'h00, 8'h00, 12'd1, -1},
	'{OP_ADDR,     25'h0002000, 8'h00, 8'h00, 12'd0, -1},
	'{OP_M1,       25'h0000065, 8'h00, 8'h00, 12'd0, -1},	// Hide
	'{OP_IO_WR,    25'h000FEE8, 8'h00, 8'h00, 12'h000, -1},
	'{OP_ADDR,     25'h0000100, 8'h00, 8'h00, 12'd0, -1},
	'{OP_KEY,      25'h0000000, 8'h00, 8'h00, 12'd1, -1},
	'{OP_M1,       25'h0000066, 8'h00, 8'h00, 12'd0, -1},
	'{OP_ADDR,     25'h0000100, 8'h00, 8'h00, 12'd1, -1},
	'{OP_IO_WR,    25'h000FEEB, 8'h00, 8'h00, 12'h000, -1},	// Not the MF2 port
	'{OP_ADDR,     25'h0000100, 8'h00, 8'h00, 12'd1, -1},
	'{OP_IO_WR,    25'h000FEEA, 8'h00, 8'h00, 12'h000, -1},
	'{OP_ADDR,     25'h0000100, 8'h00, 8'h00, 12'd0, -1},
	'{OP_DONE,     25'h0000000, 8'd4,  8'h00, 12'h000, -1},
	////////////////////////////////////////
	// Disabled mode
	'{OP_MODE,     25'h0000000, 8'h02, 8'h00, 12'h000, -1},
	'{OP_KEY,      25'h0000000, 8'h00, 8'h00, 12'd0, -1},
	'{OP_M1,       25'h0000066, 8'h00, 8'h00, 12'd0, -1},
	'{OP_IO_WR,    25'h000FEE8, 8'h00, 8'h00, 12'h000, -1},
	'{OP_ADDR,     25'h0000100, 8'h00, 8'h00, 12'd0, -1},
	'{OP_RD,       25'h0003F95, 8'h00, 8'h00, 12'h0FF, -1},
	'{OP_DONE,     25'h0000000, 8'd5,  8'h00, 12'h000, -1}
};

`endif

// File: dv/tb_cpc_expansion.sv
/*
 * CPC expansion testbench
 * Runs the vector table through the ROM loader and the Multiface Two
 */
`timescale 1ns/1ps

module tb_cpc_expansion;

	`include "tb_cpc_vectors.svh"

	logic                          clk_sys;
	logic                          reset;
	cpc_pkg::dl_ctrl_t             dl;
	cpc_pkg::dl_write_t            dl_wr;
	logic                          model;
	cpc_pkg::mf2_mode_e            mf2_mode;
	cpc_pkg::cpu_bus_t             cpu;
	logic                          key_nmi;
	cpc_pkg::boot_wr_t             boot;
	cpc_pkg::boot_wr_t             exp_boot;
	logic [cpc_pkg::ROM_SLOTS-1:0] rom_map;
	logic [cpc_pkg::ROM_SLOTS-1:0] map_model;	// Pages written in the high half
	logic                          nmi;
	logic                          rom_en;
	logic [7:0]                    mf2_dout;
	logic [7:0]                    drawn [$];
	int                            cycles = 0;
	int                            checks = 0;
	int                            errors = 0;

	cpc_expansion_top dut (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.dl_i         (dl),
		.dl_wr_i      (dl_wr),
		.model_i      (model),
		.mf2_mode_i   (mf2_mode),
		.cpu_i        (cpu),
		.key_nmi_i    (key_nmi),
		.boot_o       (boot),
		.rom_map_o    (rom_map),
		.nmi_o        (nmi),
		.mf2_rom_en_o (rom_en),
		.mf2_dout_o   (mf2_dout)
	);

	initial clk_sys = 1'b0;
	always #20 clk_sys = ~clk_sys;

	// Worst row takes two cycles
	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= $size(vecs) * 8 + 50) begin
			$display("timeout after %0d cycles, the vector table never finished", cycles);
			$display("Result: FAILED");
			$finish;
		end
	end

	task automatic step();
		@(posedge clk_sys);
		#5;
	endtask

	////////////////////////////////////////
	// Compare tasks
	task automatic check_boot(input cpc_pkg::boot_wr_t act, input cpc_pkg::boot_wr_t exp,
			input string msg);
		checks++;
		if (act.wr !== exp.wr || (exp.wr && act !== exp)) begin
			errors++;
			$display("mismatch at %0t ns: %s boot write, got %h expected %h",
				$time, msg, act, exp);
		end
	endtask

	task automatic check_map(input logic [cpc_pkg::ROM_SLOTS-1:0] act,
			input logic [cpc_pkg::ROM_SLOTS-1:0] exp, input string msg);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("mismatch at %0t ns: %s ROM map, got %h expected %h", $time, msg, act, exp);
		end
	endtask

	task automatic check_byte(input logic [7:0] act, input logic [7:0] exp, input string msg);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("mismatch at %0t ns: %s read data, got %h expected %h",
				$time, msg, act, exp);
		end
	endtask

	task automatic check_flag(input logic act, input logic exp, input string msg);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("mismatch at %0t ns: %s flag, got %b expected %b", $time, msg, act, exp);
		end
	endtask

	initial begin
		logic [31:0] draw;
		vec_t        vec;
		string       msg;
		int          first_check;
		int          first_err;

		draw = $urandom(19);	// Seed
		reset = 1'b1;
		dl = '0;
		dl_wr = '0;
		model = 1'b0;
		mf2_mode = cpc_pkg::MF2_ENABLED;
		cpu = '0;
		key_nmi = 1'b0;
		map_model = '0;
		first_check = 0;
		first_err = 0;
		repeat (4) @(posedge clk_sys);
		#5;
		reset = 1'b0;
		check_flag(boot.wr, 1'b0, "after reset");
		check_flag(nmi, 1'b0, "after reset");
		check_map(rom_map, map_model, "after reset");

		for (int i = 0; i < $size(vecs); i++) begin
			vec = vecs[i];
			draw = $urandom();
			drawn.push_back((vec.data & ~vec.rmask) | (draw[7:0] & vec.rmask));
			msg = $sformatf("entry %0d %s", i, vec.kind.name());
			case (vec.kind)
				OP_LD_START: begin
					dl.download = 1'b0;	// Fresh rising edge for the decoder
					step();
					dl = {1'b1, vec.data, vec.addr[15:0]};
					model = vec.addr[16];
					step();
				end
				OP_LD_WR: begin
					dl_wr.wr = 1'b1;
					dl_wr.addr = vec.addr;
					if (vec.rmask != 8'h00) dl_wr.addr.rom_v.offset = draw[21:8];
					dl_wr.data = drawn[i];
					exp_boot = {vec.exp[11], vec.exp[8:0], dl_wr.addr.rom_v.offset,
						vec.exp[10:9], drawn[i]};
					if (vec.exp[11] && vec.exp[8]) map_model[vec.exp[7:0]] = 1'b1;
					step();
					dl_wr.wr = 1'b0;
					check_boot(boot, exp_boot, msg);
					check_map(rom_map, map_model, msg);
				end
				OP_IO_WR: begin
					cpu.addr = vec.addr[15:0];
					cpu.dout = drawn[i];
					cpu.io_wr = 1'b1;
					step();
					cpu.io_wr = 1'b0;
				end
				OP_KEY, OP_M1: begin
					cpu.addr = vec.addr[15:0];
					cpu.m1 = (vec.kind == OP_M1);
					key_nmi = (vec.kind == OP_KEY);
					step();
					cpu.m1 = 1'b0;
					key_nmi = 1'b0;
					check_flag(nmi, vec.exp[0], msg);
				end
				OP_ADDR: begin
					cpu.addr = vec.addr[15:0];
					step();
					check_flag(rom_en, vec.exp[0], msg);
				end
				OP_RD: begin
					cpu.addr = vec.addr[15:0];
					cpu.mem_rd = 1'b1;
					step();
					step();	// Data two cycles after the address
					cpu.mem_rd = 1'b0;
					check_byte(mf2_dout, (vec.src < 0) ? vec.exp[7:0] : drawn[vec.src], msg);
				end
				OP_MODE: begin
					mf2_mode = cpc_pkg::mf2_mode_e'(vec.data[1:0]);
					step();
				end
				default: begin
					$display("test %0d finished: %0d checks, %0d errors", vec.data,
						checks - first_check, errors - first_err);
					first_check = checks;
					first_err = errors;
				end
			endcase
		end

		$display("all tests done: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// File: verilog/cpc_expansion_top.sv
/*
 * CPC expansion top
 * ROM download mapper next to the Multiface Two store map, control
 * and RAM
 */
`timescale 1ns/1ps

module cpc_expansion_top (
	input  logic                             clk_sys,
	input  logic                             reset,
	input  cpc_pkg::dl_ctrl_t                dl_i,
	input  cpc_pkg::dl_write_t               dl_wr_i,
	input  logic                             model_i,
	input  cpc_pkg::mf2_mode_e               mf2_mode_i,
	input  cpc_pkg::cpu_bus_t                cpu_i,
	input  logic                             key_nmi_i,
	output cpc_pkg::boot_wr_t                boot_o,
	output logic [cpc_pkg::ROM_SLOTS-1:0]    rom_map_o,
	output logic                             nmi_o,
	output logic                             mf2_rom_en_o,
	output logic [7:0]                       mf2_dout_o
);

	logic [cpc_pkg::MF2_RAM_AW-1:0] store_addr;
	logic                           ram_sel;

	rom_loader u_rom_loader (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.dl_i      (dl_i),
		.wr_i      (dl_wr_i),
		.model_i   (model_i),
		.boot_o    (boot_o),
		.rom_map_o (rom_map_o)
	);

	////////////////////////////////////////
	// Multiface Two
	mf2_store_map u_mf2_store_map (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.cpu_i        (cpu_i),
		.store_addr_o (store_addr)
	);

	mf2_control u_mf2_control (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.cpu_i     (cpu_i),
		.key_nmi_i (key_nmi_i),
		.mode_i    (mf2_mode_i),
		.nmi_o     (nmi_o),
		.rom_en_o  (mf2_rom_en_o),
		.ram_sel_o (ram_sel)
	);

	mf2_ram u_mf2_ram (
		.clk_sys      (clk_sys),
		.cpu_i        (cpu_i),
		.store_addr_i (store_addr),
		.ram_sel_i    (ram_sel),
		.dout_o       (mf2_dout_o)
	);

endmodule

// File: verilog/mf2_ram.sv
/*
 * Multiface Two 8 KB RAM
 * Register shadow stores win over CPU writes; reads are gated to FF
 * unless the MF2 RAM window was addressed
 */
`timescale 1ns/1ps

module mf2_ram (
	input  logic                              clk_sys,
	input  cpc_pkg::cpu_bus_t                 cpu_i,
	input  logic [cpc_pkg::MF2_RAM_AW-1:0]    store_addr_i,
	input  logic                              ram_sel_i,
	output logic [7:0]                        dout_o
);

	logic [7:0]       mem [2**cpc_pkg::MF2_RAM_AW];
	cpc_pkg::mf2_wr_t acc;
	logic [7:0]       rd_data;
	logic             rd_sel_q1;
	logic             rd_sel_q2;

	////////////////////////////////////////
	// Access register
	always_ff @(posedge clk_sys) begin
		if (cpu_i.io_wr && (|store_addr_i)) begin
			acc.we   <= 1'b1;
			acc.addr <= store_addr_i;
			acc.data <= cpu_i.dout;
		end else if (cpu_i.mem_wr && ram_sel_i) begin
			acc.we   <= 1'b1;
			acc.addr <= cpu_i.addr[cpc_pkg::MF2_RAM_AW-1:0];
			acc.data <= cpu_i.dout;
		end else begin
			acc.we   <= 1'b0;	// Plain read
			acc.addr <= cpu_i.addr[cpc_pkg::MF2_RAM_AW-1:0];
		end
	end

	////////////////////////////////////////
	// Array, write-first
	always_ff @(posedge clk_sys) begin
		if (acc.we) begin
			mem[acc.addr] <= acc.data;
			rd_data       <= acc.data;
		end else begin
			rd_data <= mem[acc.addr];
		end
	end

	// Select follows the data through both stages
	always_ff @(posedge clk_sys) begin
		rd_sel_q1 <= cpu_i.mem_rd & ram_sel_i;
		rd_sel_q2 <= rd_sel_q1;
	end

	assign dout_o = rd_sel_q2 ? rd_data : 8'hFF;

endmodule

// File: verilog/mf2_control.sv
/*
 * Multiface Two control
 * NMI request, paging enable and hidden state, with ROM and RAM
 * selects for the lower 16 KB
 */
`timescale 1ns/1ps

module mf2_control (
	input  logic                clk_sys,
	input  logic                reset,
	input  cpc_pkg::cpu_bus_t   cpu_i,
	input  logic                key_nmi_i,
	input  cpc_pkg::mf2_mode_e  mode_i,
	output logic                nmi_o,
	output logic                rom_en_o,
	output logic                ram_sel_o
);

	logic nmi_q;
	logic en_q;
	logic hidden_q;
	logic disabled;
	logic port_wr;
	logic nmi_fetch;
	logic hide_fetch;

	assign disabled   = (mode_i == cpc_pkg::MF2_DISABLED);
	assign port_wr    = cpu_i.io_wr & ((cpu_i.addr & ~16'h0002) == cpc_pkg::MF2_PORT_BASE);
	assign nmi_fetch  = cpu_i.m1 & (cpu_i.addr == cpc_pkg::MF2_NMI_ADDR);
	assign hide_fetch = cpu_i.m1 & (cpu_i.addr == cpc_pkg::MF2_HIDE_ADDR);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			nmi_q    <= 1'b0;
			en_q     <= 1'b0;
			hidden_q <= (mode_i != cpc_pkg::MF2_ENABLED);
		end else begin
			if (key_nmi_i && !en_q && !disabled) nmi_q <= 1'b1;

			// CPU takes the NMI, page the MF2 in
			if (nmi_q && nmi_fetch) begin
				en_q     <= 1'b1;
				hidden_q <= 1'b0;
				nmi_q    <= 1'b0;
			end
			if (en_q && hide_fetch) hidden_q <= 1'b1;

			if (port_wr) en_q <= ~cpu_i.addr[1] & ~hidden_q & ~disabled;	// FEE8 on, FEEA off
		end
	end

	assign nmi_o     = nmi_q;
	assign rom_en_o  = en_q & (cpu_i.addr[15:13] == 3'b000);
	assign ram_sel_o = en_q & (cpu_i.addr[15:13] == 3'b001);

	// Pending NMI and active paging exclude each other
	a_nmi_not_paged: assert property (@(posedge clk_sys) disable iff (reset)
		nmi_q |-> !en_q);

endmodule

// File: verilog/mf2_store_map.sv
/*
 * MF2 register shadow map
 * Picks the MF2 RAM location that mirrors each gate-array, CRTC,
 * 8255 or upper-ROM write
 */
`timescale 1ns/1ps

module mf2_store_map (
	input  logic                              clk_sys,
	input  logic                              reset,
	input  cpc_pkg::cpu_bus_t                 cpu_i,
	output logic [cpc_pkg::MF2_RAM_AW-1:0]    store_addr_o
);

	logic [4:0] pen_index;
	logic [3:0] crtc_reg;
	logic       ga_pen_wr;
	logic       crtc_sel_wr;

	assign ga_pen_wr   = cpu_i.io_wr & (cpu_i.addr[15:8] == 8'h7F) & (cpu_i.dout[7:6] == 2'b00);
	assign crtc_sel_wr = cpu_i.io_wr & (cpu_i.addr[15:8] == 8'hBC);

	// Indices for the later colour and CRTC data writes
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pen_index <= '0;
			crtc_reg  <= '0;
		end else begin
			if (ga_pen_wr) pen_index <= cpu_i.dout[4:0];
			if (crtc_sel_wr) crtc_reg <= cpu_i.dout[3:0];
		end
	end

	always_comb begin
		store_addr_o = '0;	// Not a shadowed port
		case (cpu_i.addr[15:8])
			8'h7F: begin
				case (cpu_i.dout[7:6])
					2'b00: store_addr_o = cpc_pkg::MF2_SH_PEN;
					2'b01: begin
						if (pen_index[4])
							store_addr_o = cpc_pkg::MF2_SH_BORDER;
						else
							store_addr_o = {cpc_pkg::MF2_SH_PALETTE_BASE[12:4], pen_index[3:0]};
					end
					2'b10: store_addr_o = cpc_pkg::MF2_SH_MODE;
					default: store_addr_o = cpc_pkg::MF2_SH_BANK;
				endcase
			end
			8'hBC: store_addr_o = cpc_pkg::MF2_SH_CRTC_SEL;
			8'hBD: store_addr_o = {cpc_pkg::MF2_SH_CRTC_BASE[12:4], crtc_reg};
			8'hF7: store_addr_o = cpc_pkg::MF2_SH_PPI;	// 8255 control
			8'hDF: store_addr_o = cpc_pkg::MF2_SH_UROM;
			default: store_addr_o = '0;
		endcase
	end

endmodule

// File: verilog/rom_loader.sv
/*
 * ROM download mapper
 * Turns loader writes into SDRAM boot writes for the system images and
 * expansion ROMs, and keeps the map of loaded upper-ROM pages
 */
`timescale 1ns/1ps

module rom_loader (
	input  logic                             clk_sys,
	input  logic                             reset,
	input  cpc_pkg::dl_ctrl_t                dl_i,
	input  cpc_pkg::dl_write_t               wr_i,
	input  logic                             model_i,
	output cpc_pkg::boot_wr_t                boot_o,
	output logic [cpc_pkg::ROM_SLOTS-1:0]    rom_map_o
);

	logic                          rom_dl;
	logic                          ext_dl;
	logic [cpc_pkg::PAGE_W-1:0]    page;
	logic                          combo;
	logic                          combo_done;
	cpc_pkg::boot_wr_t             nxt;
	cpc_pkg::boot_wr_t             boot_q;
	logic [cpc_pkg::ROM_SLOTS-1:0] rom_map_q;

	assign rom_dl = dl_i.download & (dl_i.index == cpc_pkg::IDX_ROM);
	assign ext_dl = dl_i.download & (dl_i.index == cpc_pkg::IDX_EXT);

	// Last byte of a Z0 combo image
	assign combo_done = combo & ext_dl & wr_i.wr & (&wr_i.addr.ext_v.offset);

	ext_page_decode u_ext_page (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.dl_i         (dl_i),
		.combo_done_i (combo_done),
		.page_o       (page),
		.combo_o      (combo)
	);

	////////////////////////////////////////
	// Address map
	// Low 4 MB holds OS, RAM and MF2 pages, high 4 MB the upper ROMs
	always_comb begin
		nxt.wr          = wr_i.wr & (rom_dl | ext_dl);
		nxt.data        = wr_i.data;
		nxt.addr[13:0]  = wr_i.addr.rom_v.offset;
		nxt.addr[22:14] = '1;
		nxt.bank        = '0;

		if (ext_dl) begin
			nxt.addr[22]    = page[8];
			nxt.addr[21:14] = page[7:0] + wr_i.addr.ext_v.page_ofs;
			nxt.bank        = {1'b0, model_i};
		end else begin
			nxt.bank = {1'b0, wr_i.addr.rom_v.slot[2]};	// Slots 4-7 are the 664 set
			case (wr_i.addr.rom_v.slot)
				11'd0, 11'd4: nxt.addr[22:14] = cpc_pkg::PAGE_OS;
				11'd1, 11'd5: nxt.addr[22:14] = cpc_pkg::PAGE_BASIC;
				11'd2, 11'd6: nxt.addr[22:14] = cpc_pkg::PAGE_AMSDOS;
				11'd3, 11'd7: nxt.addr[22:14] = cpc_pkg::PAGE_MF2;
				default:      nxt.wr = 1'b0;	// Unknown slot dropped
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			boot_q.wr <= 1'b0;
			rom_map_q <= '0;
		end else begin
			boot_q.wr <= nxt.wr;
			if (nxt.wr && nxt.addr[22]) rom_map_q[nxt.addr[21:14]] <= 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		boot_q.addr <= nxt.addr;
		boot_q.bank <= nxt.bank;
		boot_q.data <= nxt.data;
	end

	assign boot_o    = boot_q;
	assign rom_map_o = rom_map_q;

	// A boot write always comes from a write seen during a download
	a_boot_in_download: assert property (@(posedge clk_sys) disable iff (reset)
		boot_q.wr |-> $past(dl_i.download));

endmodule

// File: verilog/ext_page_decode.sv
/*
 * Expansion ROM page decoder
 * Latches the upper-ROM page and the Z0 combo flag from the file
 * extension when an expansion download starts
 */
`timescale 1ns/1ps

module ext_page_decode (
	input  logic                         clk_sys,
	input  logic                         reset,
	input  cpc_pkg::dl_ctrl_t            dl_i,
	input  logic                         combo_done_i,
	output logic [cpc_pkg::PAGE_W-1:0]   page_o,
	output logic                         combo_o
);

	logic                       dl_q;
	logic [cpc_pkg::PAGE_W-1:0] page_q;
	logic [cpc_pkg::PAGE_W-1:0] page_nxt;
	logic                       combo_q;
	logic [4:0]                 hi_nib;
	logic [4:0]                 lo_nib;
	logic                       ext_start;

	// Valid flag on top, nibble value below
	function automatic logic [4:0] hex_nibble(input logic [7:0] ch);
		logic [4:0] res;
		res = 5'b0;
		if (ch >= "0" && ch <= "9")
			res = {1'b1, ch[3:0]};
		else if (ch >= "A" && ch <= "F")
			res = {1'b1, ch[3:0] + 4'd9};
		return res;
	endfunction

	assign ext_start = dl_i.download & ~dl_q & (dl_i.index == cpc_pkg::IDX_EXT);
	assign hi_nib    = hex_nibble(dl_i.file_ext[15:8]);
	assign lo_nib    = hex_nibble(dl_i.file_ext[7:0]);

	always_comb begin
		page_nxt = cpc_pkg::PAGE_BAD_EXT;
		if (hi_nib[4]) page_nxt[7:4] = hi_nib[3:0];
		if (lo_nib[4]) page_nxt[3:0] = lo_nib[3:0];
		if (dl_i.file_ext == "ZZ" || dl_i.file_ext == "Z0") page_nxt = '0;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_q    <= 1'b0;
			page_q  <= '0;
			combo_q <= 1'b0;
		end else begin
			dl_q <= dl_i.download;
			if (ext_start) begin
				page_q  <= page_nxt;
				combo_q <= (dl_i.file_ext == "Z0");
			end else if (combo_done_i) begin	// Combo image filled its page
				page_q  <= cpc_pkg::PAGE_COMBO_END;
				combo_q <= 1'b0;
			end
		end
	end

	assign page_o  = page_q;
	assign combo_o = combo_q;

endmodule

// File: verilog/cpc_pkg.sv
/*
 * CPC expansion package
 * Boot slot map, MF2 addresses and shadow locations, and the loader,
 * CPU and MF2 RAM bus types shared by the loader and the Multiface Two
 */
package cpc_pkg;

	////////////////////////////////////////
	// Loader and boot image map
	localparam int BANK_W      = 2;
	localparam int BOOT_ADDR_W = 23;	// One 8 MB SDRAM bank
	localparam int PAGE_W      = 9;		// Top bit picks the upper-ROM half
	localparam int ROM_SLOTS   = 256;

	localparam logic [PAGE_W-1:0] PAGE_OS        = 9'h000;
	localparam logic [PAGE_W-1:0] PAGE_BASIC     = 9'h100;
	localparam logic [PAGE_W-1:0] PAGE_AMSDOS    = 9'h107;
	localparam logic [PAGE_W-1:0] PAGE_MF2       = 9'h0FF;
	localparam logic [PAGE_W-1:0] PAGE_BAD_EXT   = 9'h1EE;	// Unused page, bad extension
	localparam logic [PAGE_W-1:0] PAGE_COMBO_END = 9'h1FF;

	localparam logic [7:0] IDX_ROM = 8'd0;
	localparam logic [7:0] IDX_EXT = 8'd3;

	////////////////////////////////////////
	// Multiface Two
	localparam int MF2_RAM_AW = 13;

	localparam logic [15:0] MF2_NMI_ADDR  = 16'h0066;
	localparam logic [15:0] MF2_HIDE_ADDR = 16'h0065;
	localparam logic [15:0] MF2_PORT_BASE = 16'hFEE8;	// Bit 1 selects FEEA

	// Where the hardware registers are mirrored in MF2 RAM
	localparam logic [MF2_RAM_AW-1:0] MF2_SH_PEN          = 13'h1FCF;
	localparam logic [MF2_RAM_AW-1:0] MF2_SH_BORDER       = 13'h1FDF;
	localparam logic [MF2_RAM_AW-1:0] MF2_SH_PALETTE_BASE = 13'h1F90;
	localparam logic [MF2_RAM_AW-1:0] MF2_SH_MODE         = 13'h1FEF;
	localparam logic [MF2_RAM_AW-1:0] MF2_SH_BANK         = 13'h1FFF;
	localparam logic [MF2_RAM_AW-1:0] MF2_SH_CRTC_SEL     = 13'h1CFF;
	localparam logic [MF2_RAM_AW-1:0] MF2_SH_CRTC_BASE    = 13'h1DB0;
	localparam logic [MF2_RAM_AW-1:0] MF2_SH_PPI          = 13'h17FF;
	localparam logic [MF2_RAM_AW-1:0] MF2_SH_UROM         = 13'h1AAC;

	typedef enum logic [1:0] {
		MF2_ENABLED  = 2'd0,
		MF2_HIDDEN   = 2'd1,
		MF2_DISABLED = 2'd2
	} mf2_mode_e;

	////////////////////////////////////////
	// Bus types
	typedef struct packed {
		logic        download;
		logic [7:0]  index;
		logic [15:0] file_ext;	// Last two characters of the extension
	} dl_ctrl_t;

	// Loader address, seen as a ROM slot or as an expansion page offset
	typedef union packed {
		struct packed {
			logic [10:0] slot;
			logic [13:0] offset;
		} rom_v;
		struct packed {
			logic [2:0]  spare;
			logic [7:0]  page_ofs;
			logic [13:0] offset;
		} ext_v;
	} dl_addr_u;

	typedef struct packed {
		logic     wr;
		dl_addr_u addr;
		logic [7:0] data;
	} dl_write_t;

	typedef struct packed {
		logic                   wr;
		logic [BOOT_ADDR_W-1:0] addr;
		logic [BANK_W-1:0]      bank;
		logic [7:0]             data;
	} boot_wr_t;

	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  dout;
		logic        mem_rd;
		logic        mem_wr;
		logic        io_wr;
		logic        m1;
	} cpu_bus_t;

	typedef struct packed {
		logic                  we;
		logic [MF2_RAM_AW-1:0] addr;
		logic [7:0]            data;
	} mf2_wr_t;

endpackage
